// ==== design/matrix_pkg.sv ====
`default_nettype none

package matrix_pkg;

    // 64x32 panel, two bytes per pixel
    localparam int PIXEL_WIDTH     = 64;
    localparam int PIXEL_HEIGHT    = 32;
    localparam int BYTES_PER_PIXEL = 2;

    localparam int ROW_BITS  = $clog2(PIXEL_HEIGHT);     // 5
    localparam int COL_BITS  = $clog2(PIXEL_WIDTH);      // 6
    localparam int SEL_BITS  = $clog2(BYTES_PER_PIXEL);  // 1
    localparam int ADDR_BITS = ROW_BITS + COL_BITS + SEL_BITS;

    localparam int ROW_BYTES = PIXEL_WIDTH * BYTES_PER_PIXEL;

    typedef logic [ADDR_BITS-1:0] fb_addr_t;

    // one byte write into the frame buffer
    typedef struct packed {
        logic       en;
        fb_addr_t   addr;
        logic [7:0] data;
    } fb_write_t;

endpackage

`default_nettype wire

// ==== design/cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

    // host command bytes
    localparam logic [7:0] CMD_RED_ON     = "R";
    localparam logic [7:0] CMD_RED_OFF    = "r";
    localparam logic [7:0] CMD_GREEN_ON   = "G";
    localparam logic [7:0] CMD_GREEN_OFF  = "g";
    localparam logic [7:0] CMD_BLUE_ON    = "B";
    localparam logic [7:0] CMD_BLUE_OFF   = "b";
    localparam logic [7:0] CMD_ALL_OFF    = "0";
    localparam logic [7:0] CMD_ALL_ON     = "9";
    localparam logic [7:0] CMD_BRIGHTNESS = "T";
    localparam logic [7:0] CMD_ROW        = "L";
    localparam logic [7:0] CMD_PIXEL      = "P";

    typedef enum logic [1:0] {
        IDLE,
        READ_BRIGHTNESS,
        READ_ROW,
        READ_PIXEL
    } decoder_state_t;

    // first argument byte ends up in row
    typedef struct packed {
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] hi;
        logic [7:0] lo;
    } pixel_cmd_t;

    typedef struct packed {
        logic [7:0] mask;
    } brightness_cmd_t;

    // single-cycle update for the output registers
    typedef struct packed {
        logic [2:0] rgb_set;
        logic [2:0] rgb_clr;
        logic [7:0] toggle;
        logic       all_on;
        logic       all_off;
        logic       load;
        logic [7:0] load_mask;
    } display_cmd_t;

endpackage

`default_nettype wire

// ==== design/payload_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_collector #(
    parameter type payload_t = logic [7:0],
    parameter int  NUM_BYTES = 1
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output payload_t   payload,
    output logic       done
);

    localparam int W     = NUM_BYTES * 8;
    localparam int CNT_W = $clog2(NUM_BYTES + 1);

    logic [W-1:0]     shreg;
    logic [CNT_W-1:0] cnt;

    assign payload = payload_t'(shreg);

    // earlier bytes move towards the msb
    always_ff @(posedge clk_in) begin
        if (enable && rx_valid)
            shreg <= (shreg << 8) | W'(rx_data);
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!enable) begin
                cnt <= '0;
            end else if (rx_valid) begin
                if (cnt == CNT_W'(NUM_BYTES - 1)) begin
                    cnt  <= '0;
                    done <= 1'b1;       // payload complete
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fb_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_writer
    import matrix_pkg::*;
    import cmd_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset,
    input  logic       row_enable,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       pix_done,
    input  pixel_cmd_t pix_payload,
    output logic       row_done,
    output fb_write_t  fb_wr
);

    localparam int CNT_W = COL_BITS + SEL_BITS;

    logic                row_valid;     // row number latched
    logic [ROW_BITS-1:0] row_q;
    logic [CNT_W-1:0]    byte_cnt;
    logic                lo_pend;
    fb_addr_t            lo_addr;
    logic [7:0]          lo_data;
    logic                row_byte;

    assign row_byte = row_enable && rx_valid && row_valid;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            row_valid <= 1'b0;
            byte_cnt  <= '0;
            row_done  <= 1'b0;
            lo_pend   <= 1'b0;
        end else begin
            row_done <= 1'b0;
            lo_pend  <= pix_done;
            if (!row_enable) begin
                row_valid <= 1'b0;
                byte_cnt  <= '0;
            end else if (rx_valid) begin
                if (!row_valid) begin
                    row_valid <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == CNT_W'(ROW_BYTES - 1))
                        row_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (row_enable && rx_valid && !row_valid)
            row_q <= rx_data[ROW_BITS-1:0];
        if (pix_done) begin
            lo_addr <= {pix_payload.row[ROW_BITS-1:0], ~pix_payload.col[COL_BITS-1:0], 1'b0};
            lo_data <= pix_payload.lo;
        end
    end

    always_comb begin
        fb_wr = '0;
        if (row_byte) begin
            fb_wr.en   = 1'b1;
            fb_wr.addr = {row_q, ~byte_cnt};    // count is {col, sel}, both inverted
            fb_wr.data = rx_data;
        end else if (pix_done) begin
            fb_wr.en   = 1'b1;
            fb_wr.addr = {pix_payload.row[ROW_BITS-1:0], ~pix_payload.col[COL_BITS-1:0], 1'b1};
            fb_wr.data = pix_payload.hi;
        end else if (lo_pend) begin
            fb_wr.en   = 1'b1;                  // second half of pixel burst
            fb_wr.addr = lo_addr;
            fb_wr.data = lo_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
    import matrix_pkg::*;
(
    input  logic       clk_in,
    input  fb_write_t  fb_wr,
    input  fb_addr_t   rd_addr,
    output logic [7:0] rd_data
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    logic [7:0] mem [0:DEPTH-1];

    always_ff @(posedge clk_in) begin
        if (fb_wr.en)
            mem[fb_wr.addr] <= fb_wr.data;
    end

    // scan side read, one cycle latency
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== design/display_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_control
    import cmd_pkg::*;
#(
    parameter int BRIGHTNESS_LEVELS = 6
) (
    input  logic                         clk_in,
    input  logic                         reset,
    input  display_cmd_t                 disp_cmd,
    input  logic                         bri_done,
    input  brightness_cmd_t              bri_payload,
    output logic [2:0]                   rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);

    logic [BRIGHTNESS_LEVELS-1:0] bri_base;
    logic [BRIGHTNESS_LEVELS-1:0] bri_next;

    // mask load first, then any command decoded in the same cycle
    always_comb begin
        if (bri_done)
            bri_base = bri_payload.mask[BRIGHTNESS_LEVELS-1:0];
        else
            bri_base = brightness_enable;

        if (disp_cmd.all_off)
            bri_next = '0;
        else if (disp_cmd.all_on)
            bri_next = '1;
        else
            bri_next = bri_base ^ disp_cmd.toggle[BRIGHTNESS_LEVELS-1:0];
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable        <= 3'b111;
            brightness_enable <= '1;
        end else begin
            rgb_enable        <= (rgb_enable | disp_cmd.rgb_set) & ~disp_cmd.rgb_clr;
            brightness_enable <= bri_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
    import cmd_pkg::*;
#(
    parameter int BRIGHTNESS_LEVELS = 6
) (
    input  logic         clk_in,
    input  logic         reset,
    input  logic [7:0]   rx_data,
    input  logic         rx_valid,
    input  logic         pix_done,
    input  logic         bri_done,
    input  logic         row_done,
    output logic         pix_enable,
    output logic         bri_enable,
    output logic         row_enable,
    output display_cmd_t disp_cmd,
    output logic         busy
);

    decoder_state_t state;
    decoder_state_t state_next;
    logic           cmd_done;
    logic           accept;
    logic [7:0]     digit;

    always_comb begin
        case (state)
            READ_BRIGHTNESS: cmd_done = bri_done;
            READ_ROW:        cmd_done = row_done;
            READ_PIXEL:      cmd_done = pix_done;
            default:         cmd_done = 1'b0;
        endcase
    end

    // the byte landing on a done pulse is already a new command
    assign accept = (state == IDLE) || cmd_done;
    assign busy   = !accept;
    assign digit  = rx_data - 8'h30;

    // drop enables on done so the next byte is not taken as an argument
    assign pix_enable = (state == READ_PIXEL) && !pix_done;
    assign bri_enable = (state == READ_BRIGHTNESS) && !bri_done;
    assign row_enable = (state == READ_ROW) && !row_done;

    always_comb begin
        disp_cmd   = '0;
        state_next = state;
        if (cmd_done)
            state_next = IDLE;
        if (accept && rx_valid) begin
            case (rx_data)
                CMD_RED_ON:     disp_cmd.rgb_set = 3'b001;
                CMD_RED_OFF:    disp_cmd.rgb_clr = 3'b001;
                CMD_GREEN_ON:   disp_cmd.rgb_set = 3'b010;
                CMD_GREEN_OFF:  disp_cmd.rgb_clr = 3'b010;
                CMD_BLUE_ON:    disp_cmd.rgb_set = 3'b100;
                CMD_BLUE_OFF:   disp_cmd.rgb_clr = 3'b100;
                CMD_ALL_OFF:    disp_cmd.all_off = 1'b1;
                CMD_ALL_ON:     disp_cmd.all_on = 1'b1;
                CMD_BRIGHTNESS: state_next = READ_BRIGHTNESS;
                CMD_ROW:        state_next = READ_ROW;
                CMD_PIXEL:      state_next = READ_PIXEL;
                default: begin
                    // digit d flips plane BRIGHTNESS_LEVELS-d, msb first
                    if (digit >= 8'd1 && digit <= BRIGHTNESS_LEVELS)
                        disp_cmd.toggle = 8'd1 << (BRIGHTNESS_LEVELS - digit);
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

endmodule

`default_nettype wire

// ==== design/matrix_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_ctrl_top
    import matrix_pkg::*;
    import cmd_pkg::*;
#(
    parameter int BRIGHTNESS_LEVELS = 6
) (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic [7:0]                   rx_data,
    input  logic                         rx_valid,
    input  fb_addr_t                     rd_addr,
    output logic [2:0]                   rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic                         busy,
    output logic [7:0]                   rd_data
);

    logic            pix_enable;
    logic            bri_enable;
    logic            row_enable;
    logic            pix_done;
    logic            bri_done;
    logic            row_done;
    display_cmd_t    disp_cmd;
    pixel_cmd_t      pix_payload;
    brightness_cmd_t bri_payload;
    fb_write_t       fb_wr;

    cmd_decoder #(
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) decoder (
        .clk_in     (clk_in),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .pix_done   (pix_done),
        .bri_done   (bri_done),
        .row_done   (row_done),
        .pix_enable (pix_enable),
        .bri_enable (bri_enable),
        .row_enable (row_enable),
        .disp_cmd   (disp_cmd),
        .busy       (busy)
    );

    payload_collector #(
        .payload_t (pixel_cmd_t),
        .NUM_BYTES (4)
    ) pixel_collector (
        .clk_in   (clk_in),
        .reset    (reset),
        .enable   (pix_enable),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .payload  (pix_payload),
        .done     (pix_done)
    );

    payload_collector #(
        .payload_t (brightness_cmd_t),
        .NUM_BYTES (1)
    ) brightness_collector (
        .clk_in   (clk_in),
        .reset    (reset),
        .enable   (bri_enable),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .payload  (bri_payload),
        .done     (bri_done)
    );

    fb_writer writer (
        .clk_in      (clk_in),
        .reset       (reset),
        .row_enable  (row_enable),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .pix_done    (pix_done),
        .pix_payload (pix_payload),
        .row_done    (row_done),
        .fb_wr       (fb_wr)
    );

    frame_buffer fb (
        .clk_in  (clk_in),
        .fb_wr   (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    display_control #(
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) display (
        .clk_in            (clk_in),
        .reset             (reset),
        .disp_cmd          (disp_cmd),
        .bri_done          (bri_done),
        .bri_payload       (bri_payload),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

endmodule

`default_nettype wire

// ==== tb/matrix_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_ctrl_tb
    import matrix_pkg::*;
    import cmd_pkg::*;
();

    localparam int LEVELS = 6;

    logic              clk_in;
    logic              reset;
    logic [7:0]        rx_data;
    logic              rx_valid;
    fb_addr_t          rd_addr;
    logic [2:0]        rgb_enable;
    logic [LEVELS-1:0] brightness_enable;
    logic              busy;
    logic [7:0]        rd_data;

    logic [31:0]       rng_state;
    logic [2:0]        rgb_model;
    logic [LEVELS-1:0] bri_model;
    logic [7:0]        fb_model [0:(1<<ADDR_BITS)-1];

    matrix_ctrl_top #(
        .BRIGHTNESS_LEVELS(LEVELS)
    ) uut (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rd_addr           (rd_addr),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .busy              (busy),
        .rd_data           (rd_data)
    );

    initial clk_in = 1'b0;
    always #5 clk_in = ~clk_in;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // row on top, then column and byte select both inverted
    function automatic fb_addr_t pixel_addr(input logic [7:0] row, input logic [7:0] col,
                                            input logic sel);
        return {row[ROW_BITS-1:0], ~col[COL_BITS-1:0], ~sel};
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic stop_on_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Mismatch at %0d ns: %s = %0h, expected %0h", $time, name, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic random_gap();
        logic [31:0] r;
        next_rand(r);
        repeat (r[1:0]) next_cycle();
    endtask

    // one strobe, returns one cycle later
    task automatic send_byte(input logic [7:0] b);
        rx_data  = b;
        rx_valid = 1'b1;
        next_cycle();
        rx_valid = 1'b0;
        rx_data  = 8'h00;
    endtask

    task automatic send_arg(input logic [7:0] b);
        check_value("busy", 32'(busy), 32'd1);  // still inside the command
        send_byte(b);
    endtask

    task automatic check_outputs();
        check_value("rgb_enable", 32'(rgb_enable), 32'(rgb_model));
        check_value("brightness_enable", 32'(brightness_enable), 32'(bri_model));
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles >= limit) begin
                $display("Timed out after %0d cycles waiting for busy to fall", limit);
                stop_on_failure();
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic read_check(input fb_addr_t a);
        rd_addr = a;
        next_cycle();
        check_value("rd_data", 32'(rd_data), 32'(fb_model[a]));
    endtask

    task automatic model_command(input logic [7:0] b);
        int d;
        d = int'(b) - 48;
        case (b)
            CMD_RED_ON:    rgb_model[0] = 1'b1;
            CMD_RED_OFF:   rgb_model[0] = 1'b0;
            CMD_GREEN_ON:  rgb_model[1] = 1'b1;
            CMD_GREEN_OFF: rgb_model[1] = 1'b0;
            CMD_BLUE_ON:   rgb_model[2] = 1'b1;
            CMD_BLUE_OFF:  rgb_model[2] = 1'b0;
            CMD_ALL_OFF:   bri_model = '0;     // brightness planes only
            CMD_ALL_ON:    bri_model = '1;
            default: begin
                if (d >= 1 && d <= LEVELS)
                    bri_model[LEVELS-d] = ~bri_model[LEVELS-d];
            end
        endcase
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] args;
        logic [7:0]  row;
        logic [7:0]  data;
        string       singles;
        fb_addr_t    pix_addrs [$];

        rng_state = 32'hf542295b;
        reset     = 1'b1;
        rx_data   = 8'h00;
        rx_valid  = 1'b0;
        rd_addr   = '0;
        rgb_model = 3'b111;
        bri_model = '1;
        singles   = "rgbRGBbg1234567x80B9R35G0q6";

        repeat (10) @(posedge clk_in);
        #1;
        reset = 1'b0;

        check_outputs();
        check_value("busy", 32'(busy), 32'd0);

        // single-byte commands
        for (int i = 0; i < singles.len(); i++) begin
            send_byte(singles[i]);
            model_command(singles[i]);
            check_outputs();
            check_value("busy", 32'(busy), 32'd0);
        end

        // brightness mask loads
        repeat (6) begin
            next_rand(r);
            send_byte(CMD_BRIGHTNESS);
            check_value("busy", 32'(busy), 32'd1);
            random_gap();
            send_arg(r[7:0]);
            check_value("busy", 32'(busy), 32'd0);
            check_outputs();                      // mask not yet applied
            next_cycle();
            bri_model = r[LEVELS-1:0];
            check_outputs();
        end

        // pixel writes, args in row, col, hi, lo order
        repeat (10) begin
            next_rand(args);
            send_byte(CMD_PIXEL);
            for (int i = 3; i >= 0; i--) begin
                random_gap();
                send_arg(args[i*8 +: 8]);
            end
            fb_model[pixel_addr(args[31:24], args[23:16], 1'b0)] = args[15:8];
            fb_model[pixel_addr(args[31:24], args[23:16], 1'b1)] = args[7:0];
            pix_addrs.push_back(pixel_addr(args[31:24], args[23:16], 1'b0));
            pix_addrs.push_back(pixel_addr(args[31:24], args[23:16], 1'b1));
            wait_idle(4);
            random_gap();
        end
        repeat (2) next_cycle();                  // lo byte lands on the 3rd edge
        foreach (pix_addrs[i])
            read_check(pix_addrs[i]);

        // full row stream
        send_byte(CMD_RED_ON);
        model_command(CMD_RED_ON);
        next_rand(r);
        row = r[7:0];
        send_byte(CMD_ROW);
        send_arg(row);
        for (int k = 0; k < ROW_BYTES; k++) begin
            next_rand(r);
            data = r[15:8];
            if (r[0])
                next_cycle();
            send_arg(data);
            fb_model[pixel_addr(row, 8'(k / 2), k[0])] = data;
        end
        check_value("busy", 32'(busy), 32'd0);
        send_byte(CMD_RED_OFF);                   // lands in the row_done cycle
        model_command(CMD_RED_OFF);
        check_outputs();
        for (int k = 0; k < ROW_BYTES; k++)
            read_check(pixel_addr(row, 8'(k / 2), k[0]));

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== matrix_ctrl_top.f ====
design/matrix_pkg.sv
design/cmd_pkg.sv
design/payload_collector.sv
design/fb_writer.sv
design/frame_buffer.sv
design/display_control.sv
design/cmd_decoder.sv
design/matrix_ctrl_top.sv
tb/matrix_ctrl_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := matrix_ctrl_tb
RTL_TOP    := matrix_ctrl_top
FILELIST   := matrix_ctrl_top.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
